//--- files.f
+incdir+verilog
verilog/btb_pkg.sv
verilog/btb_bank.sv
verilog/btb_update.sv
verilog/btb_hit_select.sv
verilog/stream_alloc.sv
verilog/stream_ctrl.sv
verilog/btb_fetch_top.sv
sim/tb_btb_fetch.sv

//--- Makefile
# Verilator build and run of the btb fetch testbench

TOP = tb_btb_fetch

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) \
	  -f files.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "FAIL: see errors above" sim.log; then exit 1; fi
	@grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

//--- sim/tb_btb_fetch.sv
/* btb fetch testbench
   random commits, predictions and resolves checked against a reference model */
`include "btb_macros.svh"
`timescale 1ns/1ps
`default_nettype none

module tb_btb_fetch;

  import btb_pkg::*;

  logic                    clk;
  logic                    rst;
  logic                    en;
  logic                    commit_valid;
  logic                    resolve_valid;
  commit_grp_t             commit;
  resolve_t                resolve;
  fetch_pc_t               fetch;
  logic [`BTB_NSTREAM-1:0] bno_bitmap;

  integer seed = 93511;
  int     errors = 0;
  int     checks = 0;

  // ====================
  // reference model
  pc_t                     m_pc;
  bno_num_t                m_bt;
  bno_num_t                m_bf;
  pc_t                     m_pcs [`BTB_NSTREAM];       // saved pc per stream
  logic [`BTB_NSTREAM-1:0] m_bitmap;
  btb_entry_t              m_mem [`BTB_LANES][`BTB_DEPTH];
  btb_entry_t              m_rd [`BTB_LANES];          // last bank read
  logic [`BTB_LANES-1:0]   p_we;                       // commit waiting one edge
  logic [`BTB_IDX_W-1:0]   p_idx [`BTB_LANES];
  btb_entry_t              p_ent [`BTB_LANES];

  btb_fetch_top u_dut (
    .clk           (clk),
    .rst           (rst),
    .en            (en),
    .commit_valid  (commit_valid),
    .commit        (commit),
    .resolve_valid (resolve_valid),
    .resolve       (resolve),
    .fetch         (fetch),
    .bno_bitmap    (bno_bitmap)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic compare_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  function automatic pc_t group_base(input pc_t pc);
    return {pc[`BTB_PC_W-1:`BTB_GRP_LSB], {`BTB_GRP_LSB{1'b0}}}; // 32-byte aligned
  endfunction

  task automatic model_reset();
    m_pc     = `BTB_RST_PC;
    m_bt     = bno_num_t'(1);
    m_bf     = '0;
    m_bitmap = 32'h3;                 // 0 reserved, 1 active
    for (int i = 0; i < `BTB_NSTREAM; i++) begin
      m_pcs[i] = `BTB_RST_PC;
    end
    for (int l = 0; l < `BTB_LANES; l++) begin
      m_rd[l] = '0;
      p_we[l] = 1'b0;
      for (int i = 0; i < `BTB_DEPTH; i++) begin
        m_mem[l][i] = '0;
      end
    end
  endtask

  // first taken lane at or past the fetch slot, from the last read
  function automatic hit_t predict();
    hit_t h;
    pc_t  lane_pc;
    h = '0;
    for (int l = 0; l < `BTB_LANES; l++) begin
      lane_pc = group_base(m_pc) + pc_t'(8 * l);
      if (!h.hit && l >= int'(m_pc[`BTB_LANE_LSB +: `BTB_SLOT_W]) &&
          m_rd[l].takb && m_rd[l].tag == lane_pc) begin
        h.hit     = 1'b1;
        h.tgt     = m_rd[l].tgt;
        h.fall_pc = lane_pc + 32'd8;
      end
    end
    return h;
  endfunction

  // one clock edge of the model, inputs as the dut saw them
  task automatic model_step();
    hit_t     h;
    pc_t      npc;
    bno_num_t nbt;
    bno_num_t nbf;
    bno_num_t fb;
    logic     fok;
    logic     take;
    h    = predict();
    fb   = '0;
    fok  = (m_bitmap != '1);
    for (int i = 0; i < `BTB_NSTREAM; i++) begin
      if (!m_bitmap[i] && fb == '0) fb = bno_num_t'(i); // bit 0 is always set
    end
    take = en && !resolve_valid && h.hit;
    npc  = m_pc;
    nbt  = m_bt;
    nbf  = m_bf;
    if (resolve_valid) begin
      npc = m_pcs[resolve.keep_bno];
      nbt = resolve.keep_bno;
      nbf = '0;
    end else if (take) begin
      npc = h.tgt;
      nbf = fok ? fb : '0;
    end else if (en) begin
      npc = group_base(m_pc) + 32'd32;
    end
    if (resolve_valid || en) m_pcs[nbt] = npc;
    if (take && fok) m_pcs[fb] = h.fall_pc;     // parked fall-through
    if (resolve_valid && resolve.drop_bno != '0) m_bitmap[resolve.drop_bno] = 1'b0;
    if (take && fok) m_bitmap[fb] = 1'b1;
    // read sees memory before this edge's write
    for (int l = 0; l < `BTB_LANES; l++) begin
      m_rd[l] = m_mem[l][npc[`BTB_GRP_LSB +: `BTB_IDX_W]];
      if (p_we[l]) m_mem[l][p_idx[l]] = p_ent[l];
      p_we[l]       = commit_valid && commit.lane[l].takb;
      p_idx[l]      = commit.lane[l].pc[`BTB_GRP_LSB +: `BTB_IDX_W];
      p_ent[l].takb = commit.lane[l].takb;
      p_ent[l].tag  = commit.lane[l].pc;
      p_ent[l].tgt  = commit.lane[l].tgt;
    end
    m_pc = npc;
    m_bt = nbt;
    m_bf = nbf;
  endtask

  // advance one edge, then compare just after it
  task automatic tick();
    @(posedge clk);
    if (rst) model_reset();
    else model_step();
    #1;
    compare_value("fetch_pc", m_pc, fetch.pc);
    compare_value("fetch_bno_t", 32'(m_bt), 32'(fetch.bno_t));
    compare_value("fetch_bno_f", 32'(m_bf), 32'(fetch.bno_f));
    compare_value("bno_bitmap", m_bitmap, bno_bitmap);
  endtask

  // lane 3 always taken so every group in the region predicts
  task automatic make_commit(input pc_t gbase, input pc_t region);
    for (int l = 0; l < `BTB_LANES; l++) begin
      commit.lane[l].takb = (l == `BTB_LANES - 1) || (($random(seed) & 1) != 0);
      commit.lane[l].pc   = gbase + pc_t'(8 * l);
      commit.lane[l].tgt  = region + pc_t'(32 * ($random(seed) & 7)) +
                            pc_t'(8 * ($random(seed) & 3));        // random lane offset
    end
  endtask

  task automatic pick_busy(input bno_num_t avoid, output bno_num_t pick);
    int start;
    int idx;
    pick  = '0;
    start = $random(seed) & 31;
    for (int k = 0; k < `BTB_NSTREAM; k++) begin
      idx = (start + k) % `BTB_NSTREAM;
      if (pick == '0 && idx != 0 && idx != int'(avoid) && m_bitmap[idx]) begin
        pick = bno_num_t'(idx);
      end
    end
  endtask

  initial begin
    pc_t                     region;
    pc_t                     exp_pc;
    pc_t                     hold_pc;
    logic [`BTB_NSTREAM-1:0] hold_map;
    hit_t                    h;
    bno_num_t                keep;
    bno_num_t                drop;
    int                      guard;
    rst           = 1'b1;
    en            = 1'b0;
    commit_valid  = 1'b0;
    commit        = '0;
    resolve_valid = 1'b0;
    resolve       = '0;

    // ==================== reset, sequential fetch
    repeat (4) tick();
    rst = 1'b0;
    compare_value("reset_pc", `BTB_RST_PC, fetch.pc);
    compare_value("reset_bno_t", 32'd1, 32'(fetch.bno_t));
    compare_value("reset_bno_f", 32'd0, 32'(fetch.bno_f));
    compare_value("reset_bitmap", 32'h3, bno_bitmap);
    en = 1'b1;
    for (int k = 1; k <= 8; k++) begin
      tick();
      compare_value("seq_pc", `BTB_RST_PC + 32 * k, fetch.pc); // empty btb, next group
    end

    // ==================== commits, predictions, stream fill
    en     = 1'b0;
    region = group_base(m_pc) + 32'd32;   // eight groups just ahead of fetch
    for (int g = 0; g < 8; g++) begin
      make_commit(region + pc_t'(32 * g), region);
      commit_valid = 1'b1;
      tick();
    end
    commit_valid = 1'b0;
    commit       = '0;
    repeat (2) tick();                    // writes settle
    en    = 1'b1;
    guard = 0;
    while (bno_bitmap !== '1 && guard < 100) begin
      tick();
      guard++;
    end
    if (guard >= 100) begin
      errors++;
      $display("timeout: stream bitmap never filled after %0d cycles", guard);
    end
    compare_value("full_bitmap", 32'hffff_ffff, bno_bitmap);
    repeat (4) tick();                    // hits with nothing free
    compare_value("full_bno_f", 32'd0, 32'(fetch.bno_f));
    compare_value("full_bitmap_hold", 32'hffff_ffff, bno_bitmap);

    // ==================== resolves
    for (int r = 0; r < 6; r++) begin
      pick_busy('0, keep);
      pick_busy(keep, drop);
      if (keep != '0 && drop != '0) begin
        exp_pc           = m_pcs[keep];
        resolve.keep_bno = keep;
        resolve.drop_bno = drop;
        resolve_valid    = 1'b1;
        en               = ($random(seed) & 1) != 0; // resolve wins either way
        tick();
        resolve_valid = 1'b0;
        en            = 1'b1;
        compare_value("resolve_pc", exp_pc, fetch.pc);
        compare_value("resolve_bno_t", 32'(keep), 32'(fetch.bno_t));
        compare_value("drop_bit", 32'd0, 32'(bno_bitmap[drop]));
        repeat (3) tick();
      end
    end

    // ==================== hold, commit to the index being read
    en       = 1'b0;
    hold_pc  = m_pc;
    hold_map = m_bitmap;
    repeat (3) tick();
    compare_value("hold_pc", hold_pc, fetch.pc);
    compare_value("hold_bitmap", hold_map, bno_bitmap);
    h      = predict();
    exp_pc = h.hit ? h.tgt : group_base(m_pc) + 32'd32;
    for (int l = 0; l < `BTB_LANES; l++) begin
      commit.lane[l].takb = 1'b1;         // every lane of the group being read
      commit.lane[l].pc   = group_base(m_pc) + pc_t'(8 * l);
      commit.lane[l].tgt  = group_base(m_pc) + 32'h400; // far outside the region
    end
    commit_valid        = 1'b1;
    tick();                               // captured by the update stage
    commit_valid = 1'b0;
    commit       = '0;
    tick();                               // bank write, read still old
    en = 1'b1;
    tick();
    compare_value("same_index_commit", exp_pc, fetch.pc);

    // ==================== random mix
    for (int c = 0; c < 80; c++) begin
      en            = ($random(seed) & 3) != 0;
      commit_valid  = ($random(seed) & 7) == 0;
      resolve_valid = 1'b0;
      if (commit_valid) make_commit(region + pc_t'(32 * ($random(seed) & 7)), region);
      else commit = '0;
      if (($random(seed) & 15) == 0) begin
        pick_busy('0, keep);
        pick_busy(keep, drop);
        if (keep != '0 && drop != '0) begin
          resolve.keep_bno = keep;
          resolve.drop_bno = drop;
          resolve_valid    = 1'b1;
        end
      end
      tick();
    end
    en            = 1'b0;
    commit_valid  = 1'b0;
    resolve_valid = 1'b0;
    tick();

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/btb_fetch_top.sv
/* btb fetch top
   banks, update stage, hit select and stream tracking wired together */
`include "btb_macros.svh"
`timescale 1ns/1ps
`default_nettype none

module btb_fetch_top (
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       en,
  input  wire                       commit_valid,
  input  btb_pkg::commit_grp_t      commit,
  input  wire                       resolve_valid,
  input  btb_pkg::resolve_t         resolve,
  output btb_pkg::fetch_pc_t        fetch,
  output logic [`BTB_NSTREAM-1:0]   bno_bitmap
);

  import btb_pkg::*;

  // ====================
  // bank ports
  logic [`BTB_LANES-1:0]                 we;
  logic [`BTB_LANES-1:0][`BTB_IDX_W-1:0] waddr;
  btb_entry_t [`BTB_LANES-1:0]           wdata;
  btb_entry_t [`BTB_LANES-1:0]           rdata;
  logic [`BTB_IDX_W-1:0]                 raddr;   // shared by all banks

  // prediction and streams
  hit_t     hit;
  bno_num_t free_bno;
  bno_num_t release_bno;
  logic     free_ok;
  logic     alloc;
  logic     release_v;

  btb_update u_update (
    .clk          (clk),
    .rst          (rst),
    .commit_valid (commit_valid),
    .commit       (commit),
    .we           (we),
    .waddr        (waddr),
    .wdata        (wdata)
  );

  // one bank per lane slot
  for (genvar g = 0; g < `BTB_LANES; g++) begin : g_bank
    btb_bank u_bank (
      .clk   (clk),
      .rst   (rst),
      .we    (we[g]),
      .waddr (waddr[g]),
      .wdata (wdata[g]),
      .raddr (raddr),
      .rdata (rdata[g])
    );
  end

  btb_hit_select u_hit (
    .fetch_pc (fetch.pc),
    .rdata    (rdata),
    .hit      (hit)
  );

  stream_alloc u_alloc (
    .clk         (clk),
    .rst         (rst),
    .alloc       (alloc),
    .release_v   (release_v),
    .release_bno (release_bno),
    .free_bno    (free_bno),
    .free_ok     (free_ok),
    .bno_bitmap  (bno_bitmap)
  );

  stream_ctrl u_ctrl (
    .clk           (clk),
    .rst           (rst),
    .en            (en),
    .resolve_valid (resolve_valid),
    .resolve       (resolve),
    .hit           (hit),
    .free_bno      (free_bno),
    .free_ok       (free_ok),
    .alloc         (alloc),
    .release_v     (release_v),
    .release_bno   (release_bno),
    .raddr         (raddr),
    .fetch         (fetch)
  );

endmodule

`default_nettype wire

//--- verilog/stream_ctrl.sv
/* stream controller
   per-stream pc table, active stream and the next fetch pc choice */
`include "btb_macros.svh"
`timescale 1ns/1ps
`default_nettype none

module stream_ctrl (
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      en,            // advance fetch
  input  wire                      resolve_valid, // wins over prediction
  input  btb_pkg::resolve_t        resolve,
  input  btb_pkg::hit_t            hit,
  input  btb_pkg::bno_num_t        free_bno,
  input  wire                      free_ok,
  output logic                     alloc,
  output logic                     release_v,
  output btb_pkg::bno_num_t        release_bno,
  output logic [`BTB_IDX_W-1:0]    raddr,         // bank read index
  output btb_pkg::fetch_pc_t       fetch
);

  import btb_pkg::*;

  fetch_pc_t next_fetch;
  pc_t       pcs [`BTB_NSTREAM]; // saved pc per stream
  pc_t       grp_base;
  logic      advance;            // fetch moves this edge
  logic      take;               // prediction accepted

  assign grp_base = {fetch.pc[`BTB_PC_W-1:`BTB_GRP_LSB], {`BTB_GRP_LSB{1'b0}}};
  assign advance  = en | resolve_valid;
  assign take     = en & ~resolve_valid & hit.hit;

  // requests to the allocator
  assign alloc       = take & free_ok; // park fall-through only if a stream is free
  assign release_v   = resolve_valid;
  assign release_bno = resolve.drop_bno;

  // ====================
  // next fetch pc
  always_comb begin
    next_fetch = fetch; // hold when idle, read index repeats
    if (resolve_valid) begin
      next_fetch.pc    = pcs[resolve.keep_bno]; // pick up where that stream left off
      next_fetch.bno_t = resolve.keep_bno;
      next_fetch.bno_f = '0;
    end else if (take) begin
      next_fetch.pc    = hit.tgt;
      next_fetch.bno_f = free_ok ? free_bno : '0;
    end else if (en) begin
      next_fetch.pc = grp_base + (pc_t'(1) << `BTB_GRP_LSB); // next 32-byte group
    end
  end

  // banks read the group that fetch moves to
  assign raddr = next_fetch.pc[`BTB_GRP_LSB +: `BTB_IDX_W];

  // ====================
  // state
  always_ff @(posedge clk) begin
    if (rst) begin
      fetch.pc    <= `BTB_RST_PC;
      fetch.bno_t <= bno_num_t'(1);
      fetch.bno_f <= '0;
      for (int i = 0; i < `BTB_NSTREAM; i++) begin
        pcs[i] <= `BTB_RST_PC;
      end
    end else begin
      fetch <= next_fetch;
      if (advance) begin
        pcs[next_fetch.bno_t] <= next_fetch.pc; // active slot tracks fetch
      end
      if (alloc) begin
        pcs[free_bno] <= hit.fall_pc;           // not-taken path parked here
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/stream_alloc.sv
/* stream allocator
   stream bitmap with find-first-zero allocation and release */
`include "btb_macros.svh"
`timescale 1ns/1ps
`default_nettype none

module stream_alloc (
  input  wire                         clk,
  input  wire                         rst,
  input  wire                         alloc,       // take free_bno
  input  wire                         release_v,   // give back release_bno
  input  btb_pkg::bno_num_t           release_bno,
  output btb_pkg::bno_num_t           free_bno,    // lowest clear bit
  output logic                        free_ok,     // some stream is clear
  output logic [`BTB_NSTREAM-1:0]     bno_bitmap
);

  import btb_pkg::*;

  logic [`BTB_NSTREAM-1:0] next_bitmap;

  // ====================
  // find first zero
  always_comb begin
    free_bno = '0;
    for (int i = `BTB_NSTREAM - 1; i >= 0; i--) begin
      if (!bno_bitmap[i]) begin
        free_bno = bno_num_t'(i); // lower index overrides
      end
    end
  end

  assign free_ok = ~&bno_bitmap;

  // release first, then allocate
  always_comb begin
    next_bitmap = bno_bitmap;
    if (release_v && release_bno != '0) begin
      next_bitmap[release_bno] = 1'b0;
    end
    if (alloc) begin
      next_bitmap[free_bno] = 1'b1;
    end
    next_bitmap[0] = 1'b1; // stream 0 stays reserved
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      bno_bitmap <= `BTB_NSTREAM'(3); // stream 0 reserved, stream 1 active
    end else begin
      bno_bitmap <= next_bitmap;
    end
  end

  // ====================
  // contract with the stream controller
  a_alloc_free: assert property (
    @(posedge clk) disable iff (rst)
    alloc |-> free_ok
  ) else $error("stream_alloc: alloc with every stream in use");

  a_release_nz: assert property (
    @(posedge clk) disable iff (rst)
    release_v |-> (release_bno != '0)
  ) else $error("stream_alloc: release of reserved stream 0");

endmodule

`default_nettype wire

//--- verilog/btb_hit_select.sv
/* btb hit select
   tag compare per lane and pick of the first taken lane at or past fetch pc */
`include "btb_macros.svh"
`timescale 1ns/1ps
`default_nettype none

module btb_hit_select (
  input  wire  [`BTB_PC_W-1:0]                fetch_pc,
  input  btb_pkg::btb_entry_t [`BTB_LANES-1:0] rdata,   // one entry per bank
  output btb_pkg::hit_t                        hit
);

  import btb_pkg::*;

  pc_t                       grp_base;
  pc_t [`BTB_LANES-1:0]      lane_pc;
  logic [`BTB_LANES-1:0]     lane_ok;   // lane at or after the fetch offset
  logic [`BTB_LANES-1:0]     lane_hit;  // tag match and taken
  logic [`BTB_SLOT_W-1:0]    fetch_slot;

  assign grp_base   = {fetch_pc[`BTB_PC_W-1:`BTB_GRP_LSB], {`BTB_GRP_LSB{1'b0}}};
  assign fetch_slot = fetch_pc[`BTB_LANE_LSB +: `BTB_SLOT_W];

  // ====================
  // per-lane compare
  for (genvar g = 0; g < `BTB_LANES; g++) begin : g_cmp
    assign lane_pc[g]  = grp_base + (pc_t'(g) << `BTB_LANE_LSB); // base + 8*lane
    assign lane_ok[g]  = (`BTB_SLOT_W'(g) >= fetch_slot);
    assign lane_hit[g] = lane_ok[g] & rdata[g].takb & (rdata[g].tag == lane_pc[g]);
  end

  // lowest hitting lane wins
  always_comb begin
    hit = '0;
    for (int i = `BTB_LANES - 1; i >= 0; i--) begin
      if (lane_hit[i]) begin
        hit.hit     = 1'b1;
        hit.tgt     = rdata[i].tgt;
        hit.fall_pc = lane_pc[i] + (pc_t'(1) << `BTB_LANE_LSB); // next lane pc
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/btb_update.sv
/* btb update stage
   registers a commit group and turns taken lanes into bank writes */
`include "btb_macros.svh"
`timescale 1ns/1ps
`default_nettype none

module btb_update (
  input  wire                                    clk,
  input  wire                                    rst,
  input  wire                                    commit_valid, // one-cycle pulse
  input  btb_pkg::commit_grp_t                   commit,
  output logic [`BTB_LANES-1:0]                  we,
  output logic [`BTB_LANES-1:0][`BTB_IDX_W-1:0]  waddr,
  output btb_pkg::btb_entry_t [`BTB_LANES-1:0]   wdata
);

  import btb_pkg::*;

  // one write port per lane slot
  for (genvar g = 0; g < `BTB_LANES; g++) begin : g_lane
    commit_lane_t lane_in;

    assign lane_in = commit.lane[g];

    // write enable is the only control state here
    always_ff @(posedge clk) begin
      if (rst) begin
        we[g] <= 1'b0;
      end else begin
        we[g] <= commit_valid & lane_in.takb; // not-taken lanes leave the bank alone
      end
    end

    // entry and index ride along, qualified by we
    always_ff @(posedge clk) begin
      waddr[g]      <= lane_in.pc[`BTB_GRP_LSB +: `BTB_IDX_W];
      wdata[g].takb <= lane_in.takb;
      wdata[g].tag  <= lane_in.pc;
      wdata[g].tgt  <= lane_in.tgt;
    end

    // ====================
    // a lane only ever carries a branch from its own slot,
    // otherwise hit select would look in the wrong bank
    a_lane_slot: assert property (
      @(posedge clk) disable iff (rst)
      (commit_valid && lane_in.takb) |->
        (lane_in.pc[`BTB_LANE_LSB +: `BTB_SLOT_W] == `BTB_SLOT_W'(g))
    ) else $error("btb_update: lane %0d holds a branch from another slot", g);
  end

endmodule

`default_nettype wire

//--- verilog/btb_bank.sv
/* btb bank
   one simple dual-port entry memory, registered read, old data on collision */
`include "btb_macros.svh"
`timescale 1ns/1ps
`default_nettype none

module btb_bank (
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      we,     // write port
  input  wire  [`BTB_IDX_W-1:0]    waddr,
  input  btb_pkg::btb_entry_t      wdata,
  input  wire  [`BTB_IDX_W-1:0]    raddr,  // read port
  output btb_pkg::btb_entry_t      rdata
);

  btb_pkg::btb_entry_t mem [`BTB_DEPTH];

  // ====================
  // write and read share the edge
  always_ff @(posedge clk) begin
    if (rst) begin
      // start empty so nothing predicts out of reset
      for (int i = 0; i < `BTB_DEPTH; i++) begin
        mem[i] <= '0;
      end
      rdata <= '0;
    end else begin
      if (we) begin
        mem[waddr] <= wdata;
      end
      rdata <= mem[raddr]; // same-address write lands after this read
    end
  end

endmodule

`default_nettype wire

//--- verilog/btb_pkg.sv
/* btb package
   shared packed types for fetch, commit, resolve and the btb banks */
`include "btb_macros.svh"
`default_nettype none

package btb_pkg;

  typedef logic [`BTB_PC_W-1:0]  pc_t;      // byte address
  typedef logic [`BTB_BNO_W-1:0] bno_num_t; // stream number

  // one bank entry, tag is the full branch pc
  typedef struct packed {
    logic takb; // branch predicted taken
    pc_t  tag;  // pc of the branch
    pc_t  tgt;  // where it goes
  } btb_entry_t;

  // ====================
  // commit side
  typedef struct packed {
    logic takb; // write this lane back
    pc_t  pc;   // branch pc
    pc_t  tgt;  // resolved target
  } commit_lane_t;

  // lane i carries a branch whose slot (pc[4:3]) is i
  typedef struct packed {
    commit_lane_t [`BTB_LANES-1:0] lane;
  } commit_grp_t;

  // ====================
  // fetch side
  typedef struct packed {
    pc_t      pc;    // group fetch pc
    bno_num_t bno_t; // active stream
    bno_num_t bno_f; // alternate stream, 0 if none
  } fetch_pc_t;

  typedef struct packed {
    bno_num_t keep_bno; // stream that continues
    bno_num_t drop_bno; // stream given back
  } resolve_t;

  // prediction for the current group
  typedef struct packed {
    logic hit;     // taken branch found
    pc_t  tgt;     // redirect here
    pc_t  fall_pc; // pc after the branch
  } hit_t;

endpackage

`default_nettype wire

//--- verilog/btb_macros.svh
/* btb macros
   widths, depths and lane count for the branch target buffer */
`ifndef BTB_MACROS_SVH
`define BTB_MACROS_SVH

`default_nettype none

// ====================
// address layout
`define BTB_PC_W     32            // pc width
`define BTB_LANES    4             // 8-byte lanes per fetch group
`define BTB_SLOT_W   2             // lane slot width, pc bits 4..3
`define BTB_LANE_LSB 3             // lane slot starts here
`define BTB_GRP_LSB  5             // 32-byte group, index starts here

// ====================
// storage and streams
`define BTB_DEPTH    256           // entries per bank
`define BTB_IDX_W    8             // bank index, pc bits 12..5
`define BTB_NSTREAM  32            // tracked fetch streams
`define BTB_BNO_W    5             // stream number width
`define BTB_RST_PC   32'h0000_1000 // fetch starts here

`default_nettype wire

`endif
